// ==== common/lau_macros.svh ====
// lau shared parameters
// operand width and prefix depth for the arithmetic unit
`ifndef LAU_MACROS_SVH
`define LAU_MACROS_SVH

// operand width in bits
`define LAU_WIDTH 16

// prefix network depth, ceil(log2(LAU_WIDTH))
`define LAU_DEPTH 4

`endif

// ==== common/lau_pkg.sv ====
// lau package
// speed selection, operation codes and the request/response words
// of the prefix based arithmetic unit, plus a small log2 helper
`include "lau_macros.svh"

package lau_pkg;

	// floor(log2(n)), -1 for n < 1
	function automatic int log2floor(input int n);
		int exp_v;
		int pow_v;
		exp_v = -1;
		pow_v = 1;
		while (pow_v <= n) begin
			exp_v = exp_v + 1;
			pow_v = pow_v * 2;
		end
		return exp_v;
	endfunction

	// prefix network architecture
	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // serial chain
		MEDIUM = 2'b01,  // brent-kung
		FAST   = 2'b10   // sklansky
	} speed_e;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,  // a + b + cin
		OP_SUB = 3'd1,  // a - b
		OP_LTU = 3'd2,  // unsigned a < b
		OP_LTS = 3'd3,  // signed a < b
		OP_EQ  = 3'd4   // a == b
	} lau_op_e;

	typedef struct packed {
		logic                  valid;
		lau_op_e               op;
		logic [`LAU_WIDTH-1:0] a;
		logic [`LAU_WIDTH-1:0] b;
		logic                  cin;  // add only
	} lau_req_t;

	typedef struct packed {
		logic                  valid;
		logic [`LAU_WIDTH-1:0] result;
		logic                  carry;  // zero for compares
	} lau_rsp_t;

endpackage

// ==== rtl/prefix_and_or.sv ====
// prefix and-or network
// group generate/propagate from bit 0 up to every position
// sklansky (FAST), brent-kung (MEDIUM) or serial (SLOW)
`timescale 1ns/10ps
`include "lau_macros.svh"

module prefix_and_or import lau_pkg::*; #(
	parameter int     width = `LAU_WIDTH,  // word width
	parameter speed_e speed = FAST         // architecture select
) (
	input  logic [width-1:0] gi,  // bit generate
	input  logic [width-1:0] pi,  // bit propagate
	output logic [width-1:0] go,  // group generate
	output logic [width-1:0] po   // group propagate
);

	localparam int m = $clog2(width);  // network depth

	// width and depth macros have to agree
	if (`LAU_DEPTH != log2floor(`LAU_WIDTH - 1) + 1) begin : g_depth_check
		$error("LAU_DEPTH does not match ceil(log2(LAU_WIDTH))");
	end

	if (speed == FAST) begin : g_sklansky
		logic [m:0][width-1:0] gt, pt;  // per level
		assign gt[0] = gi;
		assign pt[0] = pi;
		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar i = 0; i < width; i++) begin : g_bit
				// upper half of each 2**l block takes the lower half's top bit
				if ((i / 2**(l-1)) % 2 == 1) begin : g_black
					localparam int j = (i / 2**(l-1)) * 2**(l-1) - 1;
					assign gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][j]);
					assign pt[l][i] = pt[l-1][i] & pt[l-1][j];
				end else begin : g_white
					assign gt[l][i] = gt[l-1][i];
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign go = gt[m];
		assign po = pt[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		// m levels up the tree, m-1 levels back down
		logic [2*m-1:0][width-1:0] gt, pt;
		assign gt[0] = gi;
		assign pt[0] = pi;
		for (genvar l = 1; l < 2*m; l++) begin : g_level
			localparam int s = (l <= m) ? 2**l : 2**(2*m - l);  // node span
			for (genvar i = 0; i < width; i++) begin : g_bit
				// up: block tops, down: block mid points above the first span
				localparam bit is_black = (l <= m) ? ((i + 1) % s == 0)
					: (((i + 1) % s == s / 2) && (i >= s));
				if (is_black) begin : g_black
					assign gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][i-s/2]);
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i-s/2];
				end else begin : g_white
					assign gt[l][i] = gt[l-1][i];  // pass through
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign go = gt[2*m-1];
		assign po = pt[2*m-1];
	end else begin : g_serial
		logic [width-1:0] gt, pt;  // ripple chain
		assign gt[0] = gi[0];
		assign pt[0] = pi[0];
		for (genvar i = 1; i < width; i++) begin : g_bit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]);
			assign pt[i] = pi[i] & pt[i-1];
		end
		assign go = gt;
		assign po = pt;
	end

endmodule

// ==== adder/prefix_adder.sv ====
// prefix adder
// sum/difference and carry-out on top of the prefix network,
// with one extra level that folds in the carry-in late
`timescale 1ns/10ps
`include "lau_macros.svh"

module prefix_adder import lau_pkg::*; #(
	parameter speed_e speed = FAST
) (
	input  logic [`LAU_WIDTH-1:0] a,
	input  logic [`LAU_WIDTH-1:0] b,
	input  logic                  cin,
	input  lau_op_e               op,
	output logic [`LAU_WIDTH-1:0] sum,
	output logic                  cout
);

	localparam int n = `LAU_WIDTH;

	logic         sub;   // subtract request
	logic [n-1:0] b_op;  // b or ~b
	logic         c0;    // effective carry-in
	logic [n-1:0] g, p;  // bit terms
	logic [n-1:0] gt, pt;  // group terms from bit 0
	logic [n-1:0] c;     // carry out of each bit

	// a - b = a + ~b + 1
	assign sub  = (op == OP_SUB);
	assign b_op = sub ? ~b : b;
	assign c0   = sub ? 1'b1 : cin;

	assign g = a & b_op;
	assign p = a ^ b_op;  // xor form, doubles as half sum

	prefix_and_or #(
		.width(n),
		.speed(speed)
	) u_prefix (
		.gi(g),
		.pi(p),
		.go(gt),
		.po(pt)
	);

	// fast carry-in level, carry-in only passes through fully propagating groups
	assign c = gt | (pt & {n{c0}});

	// carry into bit i is c[i-1], c0 into bit 0
	assign sum  = p ^ {c[n-2:0], c0};
	assign cout = c[n-1];

endmodule

// ==== compare/magnitude_compare.sv ====
// magnitude comparator
// unsigned/signed less-than and equality from prefix networks,
// signed result by swapping the sign bits of a and b
`timescale 1ns/10ps
`include "lau_macros.svh"

module magnitude_compare import lau_pkg::*; #(
	parameter speed_e speed = FAST
) (
	input  logic [`LAU_WIDTH-1:0] a,
	input  logic [`LAU_WIDTH-1:0] b,
	output logic                  lt_u,
	output logic                  lt_s,
	output logic                  eq
);

	localparam int n = `LAU_WIDTH;

	logic [n-1:0] a_s, b_s;  // sign bits exchanged
	logic [n-1:0] gt_u, eq_u;  // b greater here / bits equal
	logic [n-1:0] gt_s, eq_s;
	logic [n-1:0] go_u, po_u;
	logic [n-1:0] go_s;

	// msb sits at the dominant end of the network, so the group
	// generate is decided by the first differing bit from the top
	assign gt_u = ~a & b;
	assign eq_u = ~(a ^ b);

	// negative operand looks large once the sign bits trade places
	assign a_s  = {b[n-1], a[n-2:0]};
	assign b_s  = {a[n-1], b[n-2:0]};
	assign gt_s = ~a_s & b_s;
	assign eq_s = ~(a_s ^ b_s);

	prefix_and_or #(
		.width(n),
		.speed(speed)
	) u_prefix_u (
		.gi(gt_u),
		.pi(eq_u),
		.go(go_u),
		.po(po_u)
	);

	prefix_and_or #(
		.width(n),
		.speed(speed)
	) u_prefix_s (
		.gi(gt_s),
		.pi(eq_s),
		.go(go_s),
		.po()  // equality taken from the unsigned net
	);

	assign lt_u = go_u[n-1];
	assign lt_s = go_s[n-1];
	assign eq   = po_u[n-1];  // all bits equal

endmodule

// ==== rtl/lau_result_stage.sv ====
// lau result stage
// picks sum or compare flag by op code and registers the response,
// one cycle after the request
`timescale 1ns/10ps
`include "lau_macros.svh"

module lau_result_stage import lau_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid,
	input  lau_op_e               op,
	input  logic [`LAU_WIDTH-1:0] sum,
	input  logic                  cout,
	input  logic                  lt_u,
	input  logic                  lt_s,
	input  logic                  eq,
	output lau_rsp_t              rsp
);

	logic [`LAU_WIDTH-1:0] result_d;
	logic                  carry_d;

	always_comb begin
		result_d = '0;  // flags zero extended
		carry_d  = 1'b0;
		case (op)
			OP_ADD, OP_SUB: begin
				result_d = sum;
				carry_d  = cout;
			end
			OP_LTU: result_d[0] = lt_u;
			OP_LTS: result_d[0] = lt_s;
			OP_EQ:  result_d[0] = eq;
			default: ;  // unused codes give zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp <= '0;
		end else begin
			rsp.valid <= valid;
			// hold last result while idle
			if (valid) begin
				rsp.result <= result_d;
				rsp.carry  <= carry_d;
			end
		end
	end

endmodule

// ==== rtl/lau_top.sv ====
// lau top level
// adder and comparator work on the request in parallel,
// result stage registers the combined response
`timescale 1ns/10ps
`include "lau_macros.svh"

module lau_top import lau_pkg::*; #(
	parameter speed_e speed = FAST
) (
	input  logic     clk,
	input  logic     rst_n,
	input  lau_req_t req,
	output lau_rsp_t rsp
);

	logic [`LAU_WIDTH-1:0] sum;
	logic                  cout;
	logic                  lt_u, lt_s, eq;

	prefix_adder #(
		.speed(speed)
	) u_adder (
		.a   (req.a),
		.b   (req.b),
		.cin (req.cin),
		.op  (req.op),
		.sum (sum),
		.cout(cout)
	);

	magnitude_compare #(
		.speed(speed)
	) u_compare (
		.a   (req.a),
		.b   (req.b),
		.lt_u(lt_u),
		.lt_s(lt_s),
		.eq  (eq)
	);

	lau_result_stage u_result (
		.clk  (clk),
		.rst_n(rst_n),
		.valid(req.valid),
		.op   (req.op),
		.sum  (sum),
		.cout (cout),
		.lt_u (lt_u),
		.lt_s (lt_s),
		.eq   (eq),
		.rsp  (rsp)
	);

endmodule

// ==== tb/lau_properties.sv ====
// lau response properties
// bound into lau_top, latency, reset and carry of compare ops
`timescale 1ns/10ps
`include "lau_macros.svh"

module lau_properties import lau_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input lau_req_t req,
	input lau_rsp_t rsp
);

	int assert_errors = 0;  // failed assertions so far

	// every request answered one cycle later
	a_rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |=> rsp.valid)
	else begin
		assert_errors++;
		$error("rsp.valid missing one cycle after req.valid");
	end

	// no response without a request
	a_no_extra_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		!req.valid |=> !rsp.valid)
	else begin
		assert_errors++;
		$error("rsp.valid high without req.valid one cycle earlier");
	end

	a_reset_clears: assert property (@(posedge clk)
		!rst_n |=> (!rsp.valid && rsp.result == '0 && !rsp.carry))
	else begin
		assert_errors++;
		$error("rsp not cleared by reset");
	end

	// flags only, carry stays clear
	a_cmp_no_carry: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid && (req.op inside {OP_LTU, OP_LTS, OP_EQ}) |=> !rsp.carry)
	else begin
		assert_errors++;
		$error("rsp.carry set for a compare operation");
	end

endmodule

bind lau_top lau_properties u_props (.*);

// ==== tb/lau_checker.sv ====
// lau checker
// reference model of the unit, compares each response with the
// request sampled one clock earlier and counts the mismatches
`timescale 1ns/10ps
`include "lau_macros.svh"

module lau_checker import lau_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  lau_req_t req,
	input  lau_rsp_t rsp,
	output int       value_errors,
	output int       missing_errors,
	output int       extra_errors,
	output int       reset_errors,
	output int       checked
);

	localparam int w = `LAU_WIDTH;

	lau_rsp_t exp_q[$];  // one entry in flight at most
	logic     seen_req;  // valid request sampled since reset

	initial begin
		value_errors   = 0;
		missing_errors = 0;
		extra_errors   = 0;
		reset_errors   = 0;
		checked        = 0;
		seen_req       = 1'b0;
	end

	// expected response from plain integer arithmetic
	function automatic lau_rsp_t expected_rsp(input lau_req_t r);
		lau_rsp_t   e;
		logic [w:0] wide;
		e       = '0;
		e.valid = 1'b1;
		case (r.op)
			OP_ADD: begin
				wide     = {1'b0, r.a} + {1'b0, r.b} + r.cin;
				e.result = wide[w-1:0];
				e.carry  = wide[w];
			end
			OP_SUB: begin
				e.result = r.a - r.b;  // modulo 2**w
				e.carry  = (r.a >= r.b);  // set when no borrow
			end
			OP_LTU: e.result[0] = (r.a < r.b);
			OP_LTS: e.result[0] = ($signed(r.a) < $signed(r.b));
			OP_EQ:  e.result[0] = (r.a == r.b);
			default: ;
		endcase
		return e;
	endfunction

	task automatic compare_rsp(input lau_rsp_t e);
		if (rsp.result !== e.result) begin
			value_errors++;
			$display("** Error: rsp.result expected %h, got %h at %0t",
				e.result, rsp.result, $time);
		end
		if (rsp.carry !== e.carry) begin
			value_errors++;
			$display("** Error: rsp.carry expected %h, got %h at %0t",
				e.carry, rsp.carry, $time);
		end
	endtask

	// rsp still holds last cycle's register value here
	always @(posedge clk) begin
		lau_rsp_t e;
		if (!rst_n) begin
			exp_q.delete();
			seen_req = 1'b0;
		end else begin
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				if (rsp.valid !== 1'b1) begin
					missing_errors++;
					$display("response missing one cycle after a valid request at %0t", $time);
				end else begin
					compare_rsp(e);
					checked++;
				end
			end else if (rsp.valid !== 1'b0) begin
				extra_errors++;
				$display("response valid without a request in the cycle before at %0t", $time);
			end else if (!seen_req && rsp !== lau_rsp_t'(0)) begin
				reset_errors++;
				$display("** Error: rsp expected %h before first request, got %h at %0t",
					lau_rsp_t'(0), rsp, $time);
			end
			if (req.valid) begin
				exp_q.push_back(expected_rsp(req));
				seen_req = 1'b1;
			end
		end
	end

endmodule

// ==== tb/lau_tb.sv ====
// lau testbench
// clock, reset, directed corner requests, then seeded random traffic
// into the unit, responses checked by lau_checker
`timescale 1ns/10ps
`include "lau_macros.svh"

module lau_tb import lau_pkg::*; #(
	parameter speed_e speed = FAST  // MEDIUM and SLOW runs use the same bench
);

	localparam int w        = `LAU_WIDTH;
	localparam int num_reqs = 2000;  // stimulus cycles including the directed ones
	localparam int n_dir    = 8;
	localparam int clk_ns   = 10;

	localparam logic [w-1:0] min_neg = 1 << (w - 1);  // 0x8000
	localparam logic [w-1:0] max_pos = min_neg - 1;   // 0x7fff

	logic     clk;
	logic     rst_n;
	lau_req_t req;
	lau_rsp_t rsp;
	int       value_errors, missing_errors, extra_errors, reset_errors;
	int       checked;
	int       sent;  // valid requests driven
	int       total;

	lau_top #(
		.speed(speed)
	) dut (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (req),
		.rsp  (rsp)
	);

	lau_checker u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.rsp           (rsp),
		.value_errors  (value_errors),
		.missing_errors(missing_errors),
		.extra_errors  (extra_errors),
		.reset_errors  (reset_errors),
		.checked       (checked)
	);

	initial clk = 1'b0;
	always #(clk_ns / 2) clk = ~clk;

	// next falling edge, then all request fields at once
	task automatic send(input logic v, input lau_op_e op, input logic [w-1:0] a,
			input logic [w-1:0] b, input logic cin);
		@(negedge clk);
		req.valid = v;
		req.op    = op;
		req.a     = a;
		req.b     = b;
		req.cin   = cin;
		if (v)
			sent++;
	endtask

	// corners one time in two, plain random otherwise
	function automatic logic [w-1:0] rand_operand();
		logic [w-1:0] v;
		case ($urandom_range(0, 7))
			0: v = '0;
			1: v = '1;
			2: v = min_neg;
			3: v = max_pos;
			default: v = w'($urandom);
		endcase
		return v;
	endfunction

	initial begin
		logic [w-1:0] a_v, b_v;
		lau_op_e      op_v;
		void'($urandom(60723));  // seeded once for the whole run
		rst_n  = 1'b0;
		req    = '0;
		sent   = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// back to back pairs where signed and unsigned order disagree
		send(1'b1, OP_LTU, min_neg, max_pos, 1'b0);
		send(1'b1, OP_LTS, min_neg, max_pos, 1'b0);
		send(1'b1, OP_LTU, max_pos, min_neg, 1'b0);
		send(1'b1, OP_LTS, max_pos, min_neg, 1'b0);
		send(1'b1, OP_EQ, min_neg, min_neg, 1'b0);
		send(1'b1, OP_ADD, '1, 1, 1'b1);  // wraps with carry
		send(1'b1, OP_SUB, '0, 1, 1'b0);  // borrow
		send(1'b1, OP_SUB, max_pos, max_pos, 1'b1);
		for (int i = n_dir; i < num_reqs; i++) begin
			a_v  = rand_operand();
			b_v  = ($urandom_range(0, 9) == 0) ? a_v : rand_operand();
			op_v = lau_op_e'($urandom_range(0, 4));
			send($urandom_range(0, 9) < 8, op_v, a_v, b_v, $urandom_range(0, 1));
		end
		send(1'b0, OP_ADD, '0, '0, 1'b0);  // idle
		repeat (2) @(posedge clk);  // last response due one cycle after its request
		@(negedge clk);
		total = value_errors + missing_errors + extra_errors + reset_errors
			+ dut.u_props.assert_errors;
		$write("errors: value %0d, missing %0d, extra %0d, reset %0d, assert %0d; ",
			value_errors, missing_errors, extra_errors, reset_errors,
			dut.u_props.assert_errors);
		$display("%0d of %0d checked", checked, sent);
		if (checked != sent)
			$display("number of checked responses differs from number of requests");
		if (total == 0 && checked == sent) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog over the stimulus length plus some slack
	initial begin
		#((num_reqs + 50) * clk_ns);
		$display("watchdog expired, run did not finish within %0d cycles", num_reqs + 50);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== lau.f ====
+incdir+common
common/lau_pkg.sv
rtl/prefix_and_or.sv
adder/prefix_adder.sv
compare/magnitude_compare.sv
rtl/lau_result_stage.sv
rtl/lau_top.sv
tb/lau_properties.sv
tb/lau_checker.sv
tb/lau_tb.sv

// ==== Bender.yml ====
package:
  name: lau

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lau_pkg.sv
      - rtl/prefix_and_or.sv
      - adder/prefix_adder.sv
      - compare/magnitude_compare.sv
      - rtl/lau_result_stage.sv
      - rtl/lau_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/lau_properties.sv
      - tb/lau_checker.sv
      - tb/lau_tb.sv
